//--- gen_pkg.sv
// generator shared definitions
// register map, control and mode bit positions,
// sequencer state encoding and gain scaling

`default_nettype none

package gen_pkg;

  //////////////////////////////////////////////////
  // register byte offsets
  //////////////////////////////////////////////////

  localparam logic [6:0] REG_CTL     = 7'h00;
  localparam logic [6:0] REG_TRG     = 7'h08;
  localparam logic [6:0] REG_MODE    = 7'h10;
  localparam logic [6:0] REG_SIZ     = 7'h14;
  localparam logic [6:0] REG_OFF     = 7'h18;
  localparam logic [6:0] REG_STE     = 7'h1c;
  // burst configuration
  localparam logic [6:0] REG_BDL     = 7'h24;
  localparam logic [6:0] REG_BPL     = 7'h28;
  localparam logic [6:0] REG_BPN     = 7'h2c;
  // burst status, read only
  localparam logic [6:0] REG_STS_BPL = 7'h30;
  localparam logic [6:0] REG_STS_BPN = 7'h34;
  // linear stage
  localparam logic [6:0] REG_MUL     = 7'h40;
  localparam logic [6:0] REG_SUM     = 7'h44;
  localparam logic [6:0] REG_ENA     = 7'h48;

  // control register bits, all self clearing
  localparam int CTL_STR = 0;
  localparam int CTL_STP = 1;
  localparam int CTL_SWT = 2;

  // mode register bits
  localparam int MODE_BEN = 0;
  localparam int MODE_INF = 1;

  // gain fraction bits, 2**14 is unity
  localparam int MUL_SHIFT = 14;

  // sequencer state
  typedef enum logic [1:0] {
    st_idle  = 2'd0,
    st_armed = 2'd1,
    st_run   = 2'd2
  } gen_state_t;

endpackage

`default_nettype wire

//--- gen_regs.sv
// generator register block
// decodes register bus writes into configuration,
// turns control writes into pulses, masks external triggers,
// returns status on reads and raises the interrupt

`timescale 1ns/1ns
`default_nettype none

module gen_regs #(
  parameter int DW  = 14,
  parameter int CWM = 10,
  parameter int CWF = 16,
  parameter int CWL = 32,
  parameter int CWN = 16,
  parameter int TN  = 4
) (
  input  logic                       bus,
  input  logic                       rst,
  // register bus
  input  logic                       wen,
  input  logic                       ren,
  input  logic [6:0]                 addr,
  input  logic [31:0]                wdata,
  output logic [31:0]                rdata,
  output logic                       ack,
  // triggers, status, interrupt
  input  logic [TN-1:0]              trg,
  input  gen_pkg::gen_state_t        sts_state,
  input  logic [CWL-1:0]             sts_bpl,
  input  logic [CWN-1:0]             sts_bpn,
  input  logic                       lst,
  output logic                       irq,
  // control pulses to sequencer
  output logic                       ctl_str,
  output logic                       ctl_stp,
  output logic                       ctl_trg,
  // configuration
  output logic                       cfg_ben,
  output logic                       cfg_inf,
  output logic [CWM+CWF-1:0]         cfg_siz,
  output logic [CWM+CWF-1:0]         cfg_off,
  output logic [CWM+CWF-1:0]         cfg_ste,
  output logic [CWM-1:0]             cfg_bdl,
  output logic [CWL-1:0]             cfg_bpl,
  output logic [CWN-1:0]             cfg_bpn,
  output logic signed [15:0]         cfg_mul,
  output logic signed [DW-1:0]       cfg_sum,
  output logic                       cfg_ena
);

  import gen_pkg::*;

  // trigger mask
  logic [TN-1:0] cfg_trg;
  // write to the control register
  logic          ctl_wen;

  assign ctl_wen = wen && (addr == REG_CTL);

  // one cycle acknowledge for every access
  always_ff @(posedge bus) begin
    if (rst) begin
      ack <= 1'b0;
    end else begin
      ack <= wen || ren;
    end
  end

  //////////////////////////////////////////////////
  // configuration writes
  //////////////////////////////////////////////////

  always_ff @(posedge bus) begin
    if (rst) begin
      cfg_trg <= '0;
      cfg_ben <= 1'b0;
      cfg_inf <= 1'b0;
      cfg_siz <= '0;
      cfg_off <= '0;
      cfg_ste <= '0;
      cfg_bdl <= '0;
      cfg_bpl <= '0;
      cfg_bpn <= '0;
      cfg_mul <= '0;
      cfg_sum <= '0;
      cfg_ena <= 1'b0;
    end else if (wen) begin
      case (addr)
        REG_TRG: cfg_trg <= wdata[TN-1:0];
        REG_MODE: begin
          cfg_ben <= wdata[MODE_BEN];
          cfg_inf <= wdata[MODE_INF];
        end
        // fixed point pointer settings
        REG_SIZ: cfg_siz <= wdata[CWM+CWF-1:0];
        REG_OFF: cfg_off <= wdata[CWM+CWF-1:0];
        REG_STE: cfg_ste <= wdata[CWM+CWF-1:0];
        // burst shape
        REG_BDL: cfg_bdl <= wdata[CWM-1:0];
        REG_BPL: cfg_bpl <= wdata[CWL-1:0];
        REG_BPN: cfg_bpn <= wdata[CWN-1:0];
        // linear stage
        REG_MUL: cfg_mul <= signed'(wdata[15:0]);
        REG_SUM: cfg_sum <= signed'(wdata[DW-1:0]);
        REG_ENA: cfg_ena <= wdata[0];
        default: ;
      endcase
    end
  end

  //////////////////////////////////////////////////
  // control pulses and trigger
  //////////////////////////////////////////////////

  // high for one cycle, one cycle after the write
  always_ff @(posedge bus) begin
    if (rst) begin
      ctl_str <= 1'b0;
      ctl_stp <= 1'b0;
      ctl_trg <= 1'b0;
    end else begin
      ctl_str <= ctl_wen && wdata[CTL_STR];
      ctl_stp <= ctl_wen && wdata[CTL_STP];
      // software trigger or any enabled external one
      ctl_trg <= (ctl_wen && wdata[CTL_SWT]) || (|(trg & cfg_trg));
    end
  end

  // read mux, unmapped offsets give 0
  always_ff @(posedge bus) begin
    if (ren) begin
      case (addr)
        REG_CTL:     rdata <= 32'(sts_state);
        REG_TRG:     rdata <= 32'(cfg_trg);
        REG_MODE:    rdata <= 32'({cfg_inf, cfg_ben});
        REG_SIZ:     rdata <= 32'(cfg_siz);
        REG_OFF:     rdata <= 32'(cfg_off);
        REG_STE:     rdata <= 32'(cfg_ste);
        REG_BDL:     rdata <= 32'(cfg_bdl);
        REG_BPL:     rdata <= 32'(cfg_bpl);
        REG_BPN:     rdata <= 32'(cfg_bpn);
        REG_STS_BPL: rdata <= 32'(sts_bpl);
        REG_STS_BPN: rdata <= 32'(sts_bpn);
        // signed values come back sign extended
        REG_MUL:     rdata <= 32'(cfg_mul);
        REG_SUM:     rdata <= 32'(cfg_sum);
        REG_ENA:     rdata <= 32'(cfg_ena);
        default:     rdata <= '0;
      endcase
    end
  end

  // interrupt one cycle after last period
  always_ff @(posedge bus) begin
    if (rst) begin
      irq <= 1'b0;
    end else begin
      irq <= lst;
    end
  end

endmodule

`default_nettype wire

//--- gen_table.sv
// waveform table
// dual port RAM, CPU port with acknowledge for load and
// readback, generator port read every cycle

`timescale 1ns/1ns
`default_nettype none

module gen_table #(
  parameter int DW  = 14,
  parameter int CWM = 10
) (
  input  logic           bus,
  input  logic           rst,
  // CPU port
  input  logic           tbl_wen,
  input  logic           tbl_ren,
  input  logic [CWM-1:0] tbl_addr,
  input  logic [DW-1:0]  tbl_wdata,
  output logic [DW-1:0]  tbl_rdata,
  output logic           tbl_ack,
  // generator port
  input  logic [CWM-1:0] rd_addr,
  output logic [DW-1:0]  rd_data
);

  // one word per table address
  logic [DW-1:0] mem [2**CWM];

  // CPU write and read
  always_ff @(posedge bus) begin
    if (tbl_wen) begin
      mem[tbl_addr] <= tbl_wdata;
    end
    if (tbl_ren) begin
      tbl_rdata <= mem[tbl_addr];
    end
  end

  // acknowledge one cycle after either access
  always_ff @(posedge bus) begin
    if (rst) begin
      tbl_ack <= 1'b0;
    end else begin
      tbl_ack <= tbl_wen || tbl_ren;
    end
  end

  // generator read, one cycle latency
  always_ff @(posedge bus) begin
    rd_data <= mem[rd_addr];
  end

endmodule

`default_nettype wire

//--- gen_asg.sv
// address and burst sequencer
// walks the table with a fixed point pointer, runs either
// continuously or in bursts of periods, flags period start
// and last period

`timescale 1ns/1ns
`default_nettype none

module gen_asg #(
  parameter int CWM = 10,
  parameter int CWF = 16,
  parameter int CWL = 32,
  parameter int CWN = 16
) (
  input  logic                bus,
  input  logic                rst,
  // control pulses
  input  logic                ctl_str,
  input  logic                ctl_stp,
  input  logic                ctl_trg,
  // configuration
  input  logic                cfg_ben,
  input  logic                cfg_inf,
  input  logic [CWM+CWF-1:0]  cfg_siz,
  input  logic [CWM+CWF-1:0]  cfg_off,
  input  logic [CWM+CWF-1:0]  cfg_ste,
  input  logic [CWM-1:0]      cfg_bdl,
  input  logic [CWL-1:0]      cfg_bpl,
  input  logic [CWN-1:0]      cfg_bpn,
  // table address and aligned sample flags
  output logic [CWM-1:0]      rd_addr,
  output logic                smp_vld,
  output logic                smp_zero,
  // events and status
  output logic                per,
  output logic                lst,
  output gen_pkg::gen_state_t sts_state,
  output logic [CWL-1:0]      sts_bpl,
  output logic [CWN-1:0]      sts_bpn
);

  import gen_pkg::*;

  localparam int CW = CWM + CWF;

  gen_state_t     state;
  // fixed point pointer
  logic [CW-1:0]  ptr;
  logic [CW:0]    ptr_sum;
  logic [CW:0]    ptr_wrp;
  logic [CW-1:0]  ptr_nxt;
  // burst counters
  logic [CWL-1:0] bpl_cnt;
  logic [CWN-1:0] bpn_cnt;
  logic [CWL-1:0] bdl_ext;
  // decoded conditions
  logic           run;
  logic           start_run;
  logic           per_end;
  logic           bst_last;
  logic           rd_vld;
  logic           rd_zero;

  //////////////////////////////////////////////////
  // pointer arithmetic
  //////////////////////////////////////////////////

  // one extra bit so the sum cannot overflow
  assign ptr_sum = {1'b0, ptr} + {1'b0, cfg_ste};
  assign ptr_wrp = ptr_sum - {1'b0, cfg_siz};
  // wrap when the sum reaches the table size
  assign ptr_nxt = (ptr_sum >= {1'b0, cfg_siz}) ? ptr_wrp[CW-1:0] : ptr_sum[CW-1:0];

  assign run       = (state == st_run);
  assign start_run = (state == st_armed) && ctl_trg && !ctl_stp;
  assign bdl_ext   = {{(CWL-CWM){1'b0}}, cfg_bdl};

  // last cycle of a burst period
  assign per_end  = cfg_ben && (bpl_cnt == cfg_bpl - 1'b1);
  // final period, never in infinite mode
  assign bst_last = !cfg_inf && (bpn_cnt == cfg_bpn - 1'b1);

  // one sample per clock while running, gap after data length
  assign rd_vld  = run;
  assign rd_zero = run && cfg_ben && (bpl_cnt >= bdl_ext);
  assign rd_addr = ptr[CW-1:CWF];

  //////////////////////////////////////////////////
  // state machine
  //////////////////////////////////////////////////

  always_ff @(posedge bus) begin
    if (rst) begin
      state <= st_idle;
    end else if (ctl_stp) begin
      state <= st_idle;
    end else begin
      case (state)
        st_idle:  if (ctl_str) state <= st_armed;
        st_armed: if (ctl_trg) state <= st_run;
        st_run:   if (per_end && bst_last) state <= st_idle;
        default:  state <= st_idle;
      endcase
    end
  end

  // pointer and burst counters
  always_ff @(posedge bus) begin
    if (rst) begin
      ptr     <= '0;
      bpl_cnt <= '0;
      bpn_cnt <= '0;
    end else if (start_run) begin
      ptr     <= cfg_off;
      bpl_cnt <= '0;
      bpn_cnt <= '0;
    end else if (run) begin
      if (per_end) begin
        // next period restarts at the phase offset
        ptr     <= cfg_off;
        bpl_cnt <= '0;
        bpn_cnt <= bpn_cnt + 1'b1;
      end else begin
        if (cfg_ben) bpl_cnt <= bpl_cnt + 1'b1;
        // pointer holds during the gap
        if (!rd_zero) ptr <= ptr_nxt;
      end
    end
  end

  // period start and last period events
  always_ff @(posedge bus) begin
    if (rst) begin
      per <= 1'b0;
      lst <= 1'b0;
    end else begin
      per <= start_run || (run && per_end && !bst_last && !ctl_stp);
      lst <= run && per_end && bst_last && !ctl_stp;
    end
  end

  // line flags up with table read data
  always_ff @(posedge bus) begin
    if (rst) begin
      smp_vld  <= 1'b0;
      smp_zero <= 1'b0;
    end else begin
      smp_vld  <= rd_vld;
      smp_zero <= rd_zero;
    end
  end

  assign sts_state = state;
  assign sts_bpl   = bpl_cnt;
  assign sts_bpn   = bpn_cnt;

endmodule

`default_nettype wire

//--- gen_lin.sv
// linear output stage
// gain multiply, then offset add with saturation and enable,
// two register stages

`timescale 1ns/1ns
`default_nettype none

module gen_lin #(
  parameter int DW = 14
) (
  input  logic                 bus,
  input  logic                 rst,
  // samples from table
  input  logic signed [DW-1:0] smp_dat,
  input  logic                 smp_vld,
  input  logic                 smp_zero,
  // configuration
  input  logic signed [15:0]   cfg_mul,
  input  logic signed [DW-1:0] cfg_sum,
  input  logic                 cfg_ena,
  // DAC side
  output logic signed [DW-1:0] dac_dat,
  output logic                 dac_vld
);

  import gen_pkg::*;

  // full product and scaled product widths
  localparam int MW = DW + 16;
  localparam int SW = MW - MUL_SHIFT;

  logic signed [MW-1:0] prod;
  logic signed [SW-1:0] mul_q;
  logic                 vld_q;
  logic                 zero_q;
  logic signed [SW:0]   sum;
  logic                 ovf_pos;
  logic                 ovf_neg;

  assign prod = smp_dat * cfg_mul;

  //////////////////////////////////////////////////
  // stage 1, gain
  //////////////////////////////////////////////////

  // dropping the low bits is the arithmetic shift
  always_ff @(posedge bus) begin
    mul_q  <= prod[MW-1:MUL_SHIFT];
    zero_q <= smp_zero;
  end

  always_ff @(posedge bus) begin
    if (rst) begin
      vld_q <= 1'b0;
    end else begin
      vld_q <= smp_vld;
    end
  end

  // stage 2, offset and saturation
  assign sum = mul_q + cfg_sum;
  // bits above the DW range must all match the sign
  assign ovf_pos = !sum[SW] && (|sum[SW-1:DW-1]);
  assign ovf_neg = sum[SW] && !(&sum[SW-1:DW-1]);

  always_ff @(posedge bus) begin
    if (zero_q || !cfg_ena) begin
      dac_dat <= '0;
    end else if (ovf_pos) begin
      dac_dat <= {1'b0, {(DW-1){1'b1}}};
    end else if (ovf_neg) begin
      dac_dat <= {1'b1, {(DW-1){1'b0}}};
    end else begin
      dac_dat <= sum[DW-1:0];
    end
  end

  always_ff @(posedge bus) begin
    if (rst) begin
      dac_vld <= 1'b0;
    end else begin
      dac_vld <= vld_q;
    end
  end

endmodule

`default_nettype wire

//--- gen_top.sv
// waveform generator channel
// registers, sequencer, waveform table and linear stage

`timescale 1ns/1ns
`default_nettype none

module gen_top #(
  parameter int DW  = 14,
  parameter int CWM = 10,
  parameter int CWF = 16,
  parameter int CWL = 32,
  parameter int CWN = 16,
  parameter int TN  = 4
) (
  input  logic                 bus,
  input  logic                 rst,
  // register bus
  input  logic                 wen,
  input  logic                 ren,
  input  logic [6:0]           addr,
  input  logic [31:0]          wdata,
  output logic [31:0]          rdata,
  output logic                 ack,
  // table bus
  input  logic                 tbl_wen,
  input  logic                 tbl_ren,
  input  logic [CWM-1:0]       tbl_addr,
  input  logic [DW-1:0]        tbl_wdata,
  output logic [DW-1:0]        tbl_rdata,
  output logic                 tbl_ack,
  // triggers and events
  input  logic [TN-1:0]        trg,
  output logic                 irq,
  output logic                 per,
  // DAC
  output logic signed [DW-1:0] dac_dat,
  output logic                 dac_vld
);

  import gen_pkg::*;

  // control and configuration
  logic                 ctl_str;
  logic                 ctl_stp;
  logic                 ctl_trg;
  logic                 cfg_ben;
  logic                 cfg_inf;
  logic [CWM+CWF-1:0]   cfg_siz;
  logic [CWM+CWF-1:0]   cfg_off;
  logic [CWM+CWF-1:0]   cfg_ste;
  logic [CWM-1:0]       cfg_bdl;
  logic [CWL-1:0]       cfg_bpl;
  logic [CWN-1:0]       cfg_bpn;
  logic signed [15:0]   cfg_mul;
  logic signed [DW-1:0] cfg_sum;
  logic                 cfg_ena;
  // status
  gen_state_t           sts_state;
  logic [CWL-1:0]       sts_bpl;
  logic [CWN-1:0]       sts_bpn;
  logic                 lst;
  // sample path
  logic [CWM-1:0]       rd_addr;
  logic [DW-1:0]        rd_data;
  logic                 smp_vld;
  logic                 smp_zero;

  gen_regs #(
    .DW (DW), .CWM (CWM), .CWF (CWF), .CWL (CWL), .CWN (CWN), .TN (TN)
  ) u_gen_regs (
    .bus (bus), .rst (rst),
    .wen (wen), .ren (ren), .addr (addr), .wdata (wdata),
    .rdata (rdata), .ack (ack),
    .trg (trg), .sts_state (sts_state), .sts_bpl (sts_bpl), .sts_bpn (sts_bpn),
    .lst (lst), .irq (irq),
    .ctl_str (ctl_str), .ctl_stp (ctl_stp), .ctl_trg (ctl_trg),
    .cfg_ben (cfg_ben), .cfg_inf (cfg_inf),
    .cfg_siz (cfg_siz), .cfg_off (cfg_off), .cfg_ste (cfg_ste),
    .cfg_bdl (cfg_bdl), .cfg_bpl (cfg_bpl), .cfg_bpn (cfg_bpn),
    .cfg_mul (cfg_mul), .cfg_sum (cfg_sum), .cfg_ena (cfg_ena)
  );

  gen_asg #(
    .CWM (CWM), .CWF (CWF), .CWL (CWL), .CWN (CWN)
  ) u_gen_asg (
    .bus (bus), .rst (rst),
    .ctl_str (ctl_str), .ctl_stp (ctl_stp), .ctl_trg (ctl_trg),
    .cfg_ben (cfg_ben), .cfg_inf (cfg_inf),
    .cfg_siz (cfg_siz), .cfg_off (cfg_off), .cfg_ste (cfg_ste),
    .cfg_bdl (cfg_bdl), .cfg_bpl (cfg_bpl), .cfg_bpn (cfg_bpn),
    .rd_addr (rd_addr), .smp_vld (smp_vld), .smp_zero (smp_zero),
    .per (per), .lst (lst),
    .sts_state (sts_state), .sts_bpl (sts_bpl), .sts_bpn (sts_bpn)
  );

  // table read data lines up with smp_vld
  gen_table #(
    .DW (DW), .CWM (CWM)
  ) u_gen_table (
    .bus (bus), .rst (rst),
    .tbl_wen (tbl_wen), .tbl_ren (tbl_ren), .tbl_addr (tbl_addr),
    .tbl_wdata (tbl_wdata), .tbl_rdata (tbl_rdata), .tbl_ack (tbl_ack),
    .rd_addr (rd_addr), .rd_data (rd_data)
  );

  gen_lin #(
    .DW (DW)
  ) u_gen_lin (
    .bus (bus), .rst (rst),
    .smp_dat (rd_data), .smp_vld (smp_vld), .smp_zero (smp_zero),
    .cfg_mul (cfg_mul), .cfg_sum (cfg_sum), .cfg_ena (cfg_ena),
    .dac_dat (dac_dat), .dac_vld (dac_vld)
  );

endmodule

`default_nettype wire

//--- gen_tb.sv
// testbench for the waveform generator channel
// loads a random table, checks register and table readback,
// then applies a table of scenarios against a model of the
// pointer, burst and linear stage rules

`timescale 1ns/1ns
`default_nettype none

module gen_tb;

  import gen_pkg::*;

  localparam int DW    = 14;
  localparam int CWM   = 10;
  localparam int CWF   = 16;
  localparam int TN    = 4;
  localparam int NSCEN = 7;
  // cycles to wait for any handshake
  localparam int TOUT  = 50;

  // one scenario, signed fields as 32 bit patterns
  typedef struct packed {
    logic [1:0]    mode;
    logic [31:0]   siz;
    logic [31:0]   off;
    logic [31:0]   ste;
    logic [31:0]   bdl;
    logic [31:0]   bpl;
    logic [31:0]   bpn;
    logic [31:0]   mul;
    logic [31:0]   sum;
    logic          ena;
    logic [TN-1:0] src;
    logic [31:0]   nchk;
  } scen_t;

  //////////////////////////////////////////////////
  // scenario table
  //////////////////////////////////////////////////

  // mode siz off ste bdl bpl bpn mul sum ena src nchk
  // src 0 is the software trigger, else external bits and mask
  localparam scen_t SCEN [NSCEN] = '{
    '{2'd0, 32'h03e8_0000, 32'h0005_8000, 32'h0003_4000, 0, 0, 0, 16384, 0, 1'b1, 4'h0, 600},
    // gain near 2 saturates both ways
    '{2'd0, 32'h0064_0000, 32'h005a_0000, 32'h0001_8000, 0, 0, 0, 32767, 0, 1'b1, 4'h4, 200},
    '{2'd0, 32'h0200_0000, 32'h01f0_0000, 32'h0000_c000, 0, 0, 0, -16384, -3000, 1'b1, 4'h1,
      100},
    // output disabled
    '{2'd0, 32'h0040_0000, 32'h0000_0000, 32'h0001_0000, 0, 0, 0, 16384, 1000, 1'b0, 4'h0, 50},
    '{2'd1, 32'h0100_0000, 32'h000a_0000, 32'h0001_2000, 20, 32, 3, 16384, 100, 1'b1, 4'h0, 96},
    '{2'd1, 32'h0010_0000, 32'h0003_0000, 32'h0007_0000, 5, 8, 4, 8192, -50, 1'b1, 4'h8, 32},
    // infinite bursts, runs past bpn
    '{2'd3, 32'h0080_0000, 32'h0001_4000, 32'h0002_8000, 3, 5, 2, 20000, 0, 1'b1, 4'h0, 30}
  };

  // register readback set, last three read as 0
  localparam logic [6:0] RB_ADDR [14] = '{
    REG_TRG, REG_MODE, REG_SIZ, REG_OFF, REG_STE, REG_BDL, REG_BPL,
    REG_BPN, REG_MUL, REG_SUM, REG_ENA, REG_STS_BPL, REG_STS_BPN, 7'h3c
  };
  localparam logic [31:0] RB_VAL [14] = '{
    32'h5, 32'h3, 32'h02ab_cdef, 32'h0123_4567, 32'h00fe_dcba, 32'h2a5, 32'hdead_beef,
    32'hbeef, 32'hffff_8001, 32'hffff_e000, 32'h1, 32'h77, 32'h66, 32'h55
  };

  logic                 bus = 1'b0;
  logic                 rst;
  logic                 wen;
  logic                 ren;
  logic [6:0]           addr;
  logic [31:0]          wdata;
  logic [31:0]          rdata;
  logic                 ack;
  logic                 tbl_wen;
  logic                 tbl_ren;
  logic [CWM-1:0]       tbl_addr;
  logic [DW-1:0]        tbl_wdata;
  logic [DW-1:0]        tbl_rdata;
  logic                 tbl_ack;
  logic [TN-1:0]        trg;
  logic                 irq;
  logic                 per;
  logic [DW-1:0]        dac_dat;
  logic                 dac_vld;

  // model of the table and expected samples
  logic [DW-1:0] tbl_model [2**CWM];
  logic [DW-1:0] exp_q [$];

  int chk_cnt = 0;
  int err_cnt = 0;
  int mon_err = 0;
  int per_cnt = 0;
  int irq_cnt = 0;
  int lst_cnt = 0;
  logic lst_d = 1'b0;

  always #10 bus = ~bus;

  gen_top #(
    .DW (DW), .CWM (CWM), .CWF (CWF), .CWL (32), .CWN (16), .TN (TN)
  ) u_gen_top (
    .bus (bus), .rst (rst),
    .wen (wen), .ren (ren), .addr (addr), .wdata (wdata), .rdata (rdata), .ack (ack),
    .tbl_wen (tbl_wen), .tbl_ren (tbl_ren), .tbl_addr (tbl_addr),
    .tbl_wdata (tbl_wdata), .tbl_rdata (tbl_rdata), .tbl_ack (tbl_ack),
    .trg (trg), .irq (irq), .per (per), .dac_dat (dac_dat), .dac_vld (dac_vld)
  );

  // event counters, irq must follow lst by one cycle
  always @(negedge bus) begin
    if (per) per_cnt++;
    if (irq) irq_cnt++;
    if (u_gen_top.lst) lst_cnt++;
    if (lst_d) begin
      assert (irq) else begin
        $display("[ERROR] %0t irq expected 1 got 0", $time);
        mon_err++;
      end
    end
    lst_d = u_gen_top.lst;
  end

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] got);
    chk_cnt++;
    assert (got == exp) else begin
      $display("[ERROR] %0t %s expected %h got %h", $time, name, exp, got);
      err_cnt++;
    end
  endtask

  // ack seen, then low again on the next cycle
  task automatic wait_ack(input bit tbl, input string what);
    int n;
    n = 0;
    while (!(tbl ? tbl_ack : ack) && n < TOUT) begin
      @(negedge bus);
      n++;
    end
    if (!(tbl ? tbl_ack : ack)) begin
      $display("%0t no acknowledge for %s", $time, what);
      err_cnt++;
    end else begin
      @(negedge bus);
      check_val(tbl ? "tbl_ack" : "ack", 0, 32'(tbl ? tbl_ack : ack));
    end
  endtask

  task automatic reg_write(input logic [6:0] a, input logic [31:0] d);
    @(negedge bus);
    wen = 1'b1;
    addr = a;
    wdata = d;
    @(negedge bus);
    wen = 1'b0;
    wait_ack(1'b0, "register write");
  endtask

  task automatic reg_check(input logic [6:0] a, input logic [31:0] exp, input string name);
    @(negedge bus);
    ren = 1'b1;
    addr = a;
    @(negedge bus);
    ren = 1'b0;
    wait_ack(1'b0, "register read");
    check_val(name, exp, rdata);
  endtask

  task automatic tbl_write(input logic [CWM-1:0] a, input logic [DW-1:0] d);
    @(negedge bus);
    tbl_wen = 1'b1;
    tbl_addr = a;
    tbl_wdata = d;
    @(negedge bus);
    tbl_wen = 1'b0;
    wait_ack(1'b1, "table write");
  endtask

  task automatic tbl_check(input logic [CWM-1:0] a);
    @(negedge bus);
    tbl_ren = 1'b1;
    tbl_addr = a;
    @(negedge bus);
    tbl_ren = 1'b0;
    wait_ack(1'b1, "table read");
    check_val("tbl_rdata", 32'(tbl_model[a]), 32'(tbl_rdata));
  endtask

  task automatic pulse_trg(input logic [TN-1:0] t);
    @(negedge bus);
    trg = t;
    @(negedge bus);
    trg = '0;
  endtask

  task automatic check_dac_idle(input int n);
    repeat (n) begin
      @(negedge bus);
      check_val("dac_vld", 0, 32'(dac_vld));
    end
  endtask

  //////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////

  // gain with 14 fraction bits, floor, then saturated offset
  function automatic logic [DW-1:0] lin_model(input logic [DW-1:0] smp, input scen_t s);
    int x;
    int v;
    int hi;
    int lo;
    hi = (1 << (DW-1)) - 1;
    lo = -(1 << (DW-1));
    x = int'($signed(smp)) * int'($signed(s.mul[15:0]));
    v = (x >>> MUL_SHIFT) + int'($signed(s.sum[DW-1:0]));
    if (v > hi) v = hi;
    if (v < lo) v = lo;
    if (!s.ena) v = 0;
    return v[DW-1:0];
  endfunction

  // wrapping pointer, restarted at the offset every period
  task automatic build_model(input scen_t s);
    longint p;
    int c;
    exp_q.delete();
    p = s.off;
    c = 0;
    while (exp_q.size() < s.nchk) begin
      if (!s.mode[MODE_BEN] || c < s.bdl) begin
        exp_q.push_back(lin_model(tbl_model[CWM'(p >> CWF)], s));
        p = p + s.ste;
        if (p >= s.siz) p = p - s.siz;
      end else begin
        exp_q.push_back('0);
      end
      c++;
      if (s.mode[MODE_BEN] && c == s.bpl) begin
        c = 0;
        p = s.off;
      end
    end
  endtask

  task automatic run_scen(input int idx, input scen_t s);
    int per0;
    int irq0;
    int lst0;
    int i;
    int n;
    $display("scenario %0d", idx);
    build_model(s);
    reg_write(REG_TRG, 32'(s.src));
    reg_write(REG_MODE, 32'(s.mode));
    reg_write(REG_SIZ, s.siz);
    reg_write(REG_OFF, s.off);
    reg_write(REG_STE, s.ste);
    reg_write(REG_BDL, s.bdl);
    reg_write(REG_BPL, s.bpl);
    reg_write(REG_BPN, s.bpn);
    reg_write(REG_MUL, s.mul);
    reg_write(REG_SUM, s.sum);
    reg_write(REG_ENA, 32'(s.ena));
    per0 = per_cnt;
    irq0 = irq_cnt;
    lst0 = lst_cnt;
    // start alone only arms
    reg_write(REG_CTL, 32'(1) << CTL_STR);
    check_dac_idle(8);
    reg_check(REG_CTL, 32'(st_armed), "state");
    if (s.src != '0) begin
      // masked off bits must not fire
      pulse_trg(~s.src);
      check_dac_idle(8);
      reg_check(REG_CTL, 32'(st_armed), "state");
      pulse_trg(s.src);
    end else begin
      reg_write(REG_CTL, 32'(1) << CTL_SWT);
    end
    i = 0;
    n = 0;
    while (i < s.nchk && n < TOUT) begin
      @(negedge bus);
      if (dac_vld) begin
        check_val("dac_dat", 32'(exp_q[i]), 32'(dac_dat));
        i++;
        n = 0;
      end else begin
        n++;
      end
    end
    if (i < s.nchk) begin
      $display("%0t scenario %0d got only %0d of %0d samples", $time, idx, i, s.nchk);
      err_cnt++;
    end
    if (s.mode == 2'd1) begin
      // finite burst stops by itself
      check_dac_idle(6);
      check_val("per count", s.bpn, 32'(per_cnt - per0));
      check_val("lst count", 1, 32'(lst_cnt - lst0));
      check_val("irq count", 1, 32'(irq_cnt - irq0));
      reg_check(REG_STS_BPN, s.bpn, "sts_bpn");
    end else begin
      reg_write(REG_CTL, 32'(1) << CTL_STP);
      repeat (4) @(negedge bus);
      check_dac_idle(5);
    end
    reg_check(REG_CTL, 32'(st_idle), "state");
  endtask

  initial begin
    int i;
    void'($urandom(2562));
    rst = 1'b1;
    wen = 1'b0;
    ren = 1'b0;
    addr = '0;
    wdata = '0;
    tbl_wen = 1'b0;
    tbl_ren = 1'b0;
    tbl_addr = '0;
    tbl_wdata = '0;
    trg = '0;
    repeat (10) @(posedge bus);
    @(negedge bus);
    rst = 1'b0;
    // idle outputs after reset
    check_val("ack", 0, 32'(ack));
    check_val("tbl_ack", 0, 32'(tbl_ack));
    check_val("dac_vld", 0, 32'(dac_vld));
    check_val("per", 0, 32'(per));
    check_val("irq", 0, 32'(irq));
    reg_check(REG_CTL, 32'(st_idle), "state");

    // random signed samples
    for (i = 0; i < 2**CWM; i++) begin
      tbl_model[i] = DW'($urandom);
      tbl_write(CWM'(i), tbl_model[i]);
    end
    for (i = 0; i < 2**CWM; i += 41) begin
      tbl_check(CWM'(i));
    end

    for (i = 0; i < 14; i++) begin
      reg_write(RB_ADDR[i], RB_VAL[i]);
    end
    for (i = 0; i < 14; i++) begin
      reg_check(RB_ADDR[i], (i < 11) ? RB_VAL[i] : 32'h0, "rdata");
    end

    for (i = 0; i < NSCEN; i++) begin
      run_scen(i, SCEN[i]);
    end

    $display("checks %0d, errors %0d, monitor errors %0d", chk_cnt, err_cnt, mon_err);
    if (err_cnt == 0 && mon_err == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

  // watchdog, table load plus every scenario with margin
  initial begin
    longint lim;
    lim = 10 + (2**CWM) * 8 + 500;
    for (int k = 0; k < NSCEN; k++) begin
      lim += SCEN[k].nchk + 400;
    end
    #(lim * 20);
    $display("watchdog expired after %0d cycles", lim);
    $display("Finished with errors");
    $finish;
  end

endmodule

`default_nettype wire

//--- project.f
gen_pkg.sv
gen_regs.sv
gen_table.sv
gen_asg.sv
gen_lin.sv
gen_top.sv
gen_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build the generator testbench with Verilator, run it, then scan the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal --top-module gen_tb -f project.f \
  && ./obj_dir/Vgen_tb > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }

cat sim.log
grep -q "Finished with errors" sim.log && { echo "RESULT: FAIL"; exit 1; }
echo "RESULT: PASS"
